// File: hw/mipsPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS subset constants: opcodes, function codes, ALU codes, memory sizes
// and the instruction word union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPkg;

    // primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opHalt  = 6'h3f; // reserved opcode, stops the PC

    // function codes for R-type
    localparam logic [5:0] fnJr  = 6'h08;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    // ALU operations
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // memory sizes in 32-bit words
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int imemAddrW = $clog2(imemDepth);
    localparam int dmemAddrW = $clog2(dmemDepth);

    localparam logic [4:0] linkReg = 5'd31; // return address register for jal

    // one instruction word seen as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFmt;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } jFmt;
    } instrWord;

endpackage

// File: hw/ctrlBus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoded control levels from decode to fetch and datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface ctrlBus;
    logic       regDst;   // write rd instead of rt
    logic       aluSrc;   // second operand is the immediate
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
    logic       branch;
    logic       jump;
    logic       jumpReg;  // jr
    logic       link;     // jal
    logic [2:0] aluOp;

    modport decode (
        output regDst, aluSrc, memWrite, memToReg, regWrite,
        output branch, jump, jumpReg, link, aluOp
    );

    modport fetch (
        input branch, jump, jumpReg
    );

    modport datapath (
        input aluSrc, aluOp, memWrite, memToReg
    );
endinterface

// File: hw/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32-bit register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    input  logic        writeEn,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != 5'd0)) begin // r0 never written
            regs[writeAddr] <= writeData;
        end
    end

    // asynchronous reads, r0 hardwired
    always_comb begin
        if (readAddr1 == 5'd0) begin
            readData1 = '0;
        end else begin
            readData1 = regs[readAddr1];
        end
    end

    always_comb begin
        if (readAddr2 == 5'd0) begin
            readData2 = '0;
        end else begin
            readData2 = regs[readAddr2];
        end
    end

endmodule

// File: hw/fetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, instruction memory with loader, next PC and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fetchUnit import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 progWe,
    input  logic [imemAddrW-1:0] progAddr,
    input  logic [31:0]          progData,
    ctrlBus.fetch                ctrl,
    input  logic                 zero,
    input  logic [31:0]          seImm,
    input  logic [31:0]          jumpRegAddr,
    output instrWord             instr,
    output logic [31:0]          pcPlus4,
    output logic                 halted
);

    logic [31:0] imem [imemDepth];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    instrWord    fetched;
    logic        running;
    logic        isHalt;

    // loader writes only while the core is stopped
    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            imem[progAddr] <= progData;
        end
    end

    assign fetched = imem[pc[imemAddrW+1:2]]; // word addressed
    assign running = run && !halted;
    assign isHalt  = running && (fetched.jFmt.op == opHalt);

    // bubble of all zeros while stopped, decodes to no write at all
    assign instr = running ? fetched : '0;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {seImm[29:0], 2'b00};
    assign jumpTarget   = {4'b0000, instr.jFmt.target, 2'b00};

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = jumpRegAddr;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (running && !isHalt) begin
            pc <= nextPc;
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
        end else if (isHalt) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: hw/decodeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control decode, write register select, sign extend, register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decodeUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  instrWord    instr,
    input  logic [31:0] pcPlus4,
    input  logic [31:0] writeData,
    ctrlBus.decode      ctrl,
    output logic [31:0] readData1,
    output logic [31:0] readData2,
    output logic [31:0] seImm
);

    logic [4:0]  writeReg;
    logic [31:0] regWriteData;

    always_comb begin
        ctrl.regDst   = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.link     = 1'b0;
        ctrl.aluOp    = aluAdd;
        case (instr.rFmt.op)
            opRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.rFmt.funct)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr:  ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnJr: begin
                        ctrl.jumpReg  = 1'b1;
                        ctrl.regWrite = 1'b0;
                    end
                    default: ctrl.regWrite = 1'b0;  // unknown funct has no effect
                endcase
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;               // equal when difference is zero
            end
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;                              // halt and reserved opcodes
        endcase
    end

    assign writeReg = ctrl.link ? linkReg :
                      (ctrl.regDst ? instr.rFmt.rd : instr.rFmt.rt);
    assign regWriteData = ctrl.link ? pcPlus4 : writeData; // jal saves return address

    assign seImm = {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm};

    regFile regs (
        .clk       (clk),
        .arstN     (arstN),
        .readAddr1 (instr.rFmt.rs),
        .readAddr2 (instr.rFmt.rt),
        .writeAddr (writeReg),
        .writeData (regWriteData),
        .writeEn   (ctrl.regWrite),
        .readData1 (readData1),
        .readData2 (readData2)
    );

endmodule

// File: hw/executeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with operand select and zero flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module executeUnit import mipsPkg::*; (
    ctrlBus.datapath    ctrl,
    input  logic [31:0] readData1,
    input  logic [31:0] readData2,
    input  logic [31:0] seImm,
    output logic [31:0] aluResult,
    output logic        zero
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic        lessThan;

    assign opA = readData1;
    assign opB = ctrl.aluSrc ? seImm : readData2; // immediate for addi, lw, sw

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {31'd0, lessThan};
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

endmodule

// File: hw/memWriteback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory, store reporting, writeback select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memWriteback import mipsPkg::*; (
    input  logic        clk,
    input  logic        run,
    ctrlBus.datapath    ctrl,
    input  logic [31:0] aluResult,
    input  logic [31:0] readData2,
    output logic [31:0] writeData,
    output logic        storeValid,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData
);

    logic [31:0]          dmem [dmemDepth];
    logic [dmemAddrW-1:0] wordIndex;
    logic                 doStore;
    logic [31:0]          loadData;

    assign wordIndex = aluResult[dmemAddrW+1:2]; // byte address to word
    assign doStore   = ctrl.memWrite && run;

    always_ff @(posedge clk) begin
        if (doStore) begin
            dmem[wordIndex] <= readData2;
        end
    end

    assign loadData = dmem[wordIndex];

    // every store shows up on the ports in the cycle it executes
    assign storeValid = doStore;
    assign storeAddr  = aluResult;
    assign storeData  = readData2;

    assign writeData = ctrl.memToReg ? loadData : aluResult;

endmodule

// File: hw/singleCycleCpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle MIPS subset top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module singleCycleCpu import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 progWe,
    input  logic [imemAddrW-1:0] progAddr,
    input  logic [31:0]          progData,
    output logic                 storeValid,
    output logic [31:0]          storeAddr,
    output logic [31:0]          storeData,
    output logic                 halted
);

    instrWord    instr;
    logic [31:0] pcPlus4;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] seImm;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] writeData;

    ctrlBus ctrl ();

    fetchUnit fetch (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .ctrl        (ctrl.fetch),
        .zero        (zero),
        .seImm       (seImm),
        .jumpRegAddr (readData1), // jr target
        .instr       (instr),
        .pcPlus4     (pcPlus4),
        .halted      (halted)
    );

    decodeUnit decode (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .pcPlus4   (pcPlus4),
        .writeData (writeData),
        .ctrl      (ctrl.decode),
        .readData1 (readData1),
        .readData2 (readData2),
        .seImm     (seImm)
    );

    executeUnit execute (
        .ctrl      (ctrl.datapath),
        .readData1 (readData1),
        .readData2 (readData2),
        .seImm     (seImm),
        .aluResult (aluResult),
        .zero      (zero)
    );

    memWriteback memWb (
        .clk        (clk),
        .run        (run),
        .ctrl       (ctrl.datapath),
        .aluResult  (aluResult),
        .readData2  (readData2),
        .writeData  (writeData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

endmodule

// File: test/tbSingleCycleCpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace-driven testbench: program load, run, store and halt checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tbSingleCycleCpu import mipsPkg::*; ();

    logic                 clk;
    logic                 arstN;
    logic                 run;
    logic                 progWe;
    logic [imemAddrW-1:0] progAddr;
    logic [31:0]          progData;
    logic                 storeValid;
    logic [31:0]          storeAddr;
    logic [31:0]          storeData;
    logic                 halted;

    logic [31:0] traceMem [0:255];  // flat list of words from the trace
    int          progCount;
    int          storeCount;
    int          storeBase;         // index of the first expected store pair
    int          storeIndex;
    int          mismatchCount;
    int          otherCount;
    bit          traceOk;
    bit          traceReady;

    singleCycleCpu dut (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .halted     (halted)
    );

    always #5 clk = ~clk;

    task automatic readTrace(output bit ok);
        $readmemh("test/cpuTrace.txt", traceMem);
        ok = 1'b0;
        if ((^traceMem[0]) !== 1'bx && traceMem[0] > 0 && traceMem[0] <= imemDepth) begin
            progCount = traceMem[0];
            storeBase = 2 * progCount + 2;
            if ((^traceMem[storeBase - 1]) !== 1'bx) begin
                storeCount = traceMem[storeBase - 1];
                ok = (storeBase + 2 * storeCount) <= 256;
            end
        end
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < progCount; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= traceMem[1 + 2 * i][imemAddrW-1:0]; // word address
            progData <= traceMem[2 + 2 * i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (halted) begin
            otherCount++;
            $display("Store to address %h appeared after halt", addr);
        end
        if (storeIndex >= storeCount) begin
            otherCount++;
            $display("Extra store beyond the %0d expected: address %h data %h",
                     storeCount, addr, data);
        end else begin
            expAddr = traceMem[storeBase + 2 * storeIndex];
            expData = traceMem[storeBase + 2 * storeIndex + 1];
            if (addr !== expAddr) begin
                mismatchCount++;
                $display("Mismatch storeAddr (store %0d): expected %h, got %h",
                         storeIndex, expAddr, addr);
            end
            if (data !== expData) begin
                mismatchCount++;
                $display("Mismatch storeData (store %0d): expected %h, got %h",
                         storeIndex, expData, data);
            end
        end
        storeIndex++;
    endtask

    // every executed sw shows up here with pre-edge values
    always @(posedge clk) begin
        if (arstN && storeValid) begin
            checkStore(storeAddr, storeData);
        end
    end

    // limit scales with program length
    initial begin
        wait (traceReady);
        repeat (20 * progCount + 100) @(posedge clk);
        otherCount++;
        $display("Timeout: halt was never reached within %0d cycles", 20 * progCount + 100);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        arstN         = 1'b0;
        run           = 1'b0;
        progWe        = 1'b0;
        progAddr      = '0;
        progData      = '0;
        storeIndex    = 0;
        mismatchCount = 0;
        otherCount    = 0;
        traceReady    = 1'b0;
        readTrace(traceOk);
        if (!traceOk) begin
            otherCount++;
            $display("Trace file test/cpuTrace.txt is missing or malformed");
            $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            traceReady = 1'b1;
            repeat (4) @(posedge clk);
            arstN <= 1'b1;
            @(posedge clk);
            if (halted !== 1'b0) begin
                mismatchCount++;
                $display("Mismatch halted after reset: expected 0, got %h", halted);
            end
            loadProgram();
            @(posedge clk);
            run <= 1'b1;
            wait (halted === 1'b1);
            repeat (10) @(posedge clk);  // no store may follow the halt
            @(negedge clk);              // monitor has seen the last edge
            if (halted !== 1'b1) begin
                mismatchCount++;
                $display("Mismatch halted after 10 cycles: expected 1, got %h", halted);
            end
            if (storeIndex < storeCount) begin
                otherCount++;
                $display("Missing stores: saw %0d of %0d expected", storeIndex, storeCount);
            end
            $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
            if (mismatchCount == 0 && otherCount == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

// File: mipsCpu.f
hw/mipsPkg.sv
hw/ctrlBus.sv
hw/regFile.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memWriteback.sv
hw/singleCycleCpu.sv
test/tbSingleCycleCpu.sv

// File: test/cpuTrace.txt
// program: word count, then lines of word address and instruction word (hex)
// stores: store count, then lines of byte address and stored data (hex)
00000020
00 20010005 // addi $1, $0, 5
01 2002FFFD // addi $2, $0, -3
02 00221820 // add  $3, $1, $2
03 AC030000 // sw   $3, 0($0)
04 00222022 // sub  $4, $1, $2
05 AC040004 // sw   $4, 4($0)
06 2005000C // addi $5, $0, 12
07 00253024 // and  $6, $1, $5
08 AC060008 // sw   $6, 8($0)
09 00253825 // or   $7, $1, $5
0A AC07000C // sw   $7, 12($0)
0B 0041402A // slt  $8, $2, $1
0C 0022482A // slt  $9, $1, $2
0D AC080010 // sw   $8, 16($0)
0E AC090014 // sw   $9, 20($0)
0F AC020018 // sw   $2, 24($0)
10 8C0A0004 // lw   $10, 4($0)
11 AC0A0020 // sw   $10, 32($0)
12 10250001 // beq  $1, $5, +1 (not taken)
13 AC010024 // sw   $1, 36($0)
14 10630001 // beq  $3, $3, +1 (taken)
15 AC010028 // sw   $1, 40($0) skipped
16 AC03002C // sw   $3, 44($0)
17 08000019 // j    0x64
18 AC010030 // sw   $1, 48($0) skipped
19 0C00001E // jal  0x78
1A 20000009 // addi $0, $0, 9
1B 00210020 // add  $0, $1, $1
1C AC000038 // sw   $0, 56($0)
1D FC000000 // halt
1E AC1F0034 // sw   $31, 52($0)
1F 03E00008 // jr   $31
0000000C
00000000 00000002 // add
00000004 00000008 // sub with a negative operand
00000008 00000004 // and
0000000C 0000000D // or
00000010 00000001 // slt, negative less than positive
00000014 00000000 // slt, false
00000018 FFFFFFFD // addi with a negative immediate
00000020 00000008 // loaded back from address 4
00000024 00000005 // beq fall-through path
0000002C 00000002 // beq target path
00000034 00000068 // link value of jal at 0x64
00000038 00000000 // register zero stays zero
